/* blender/blend_core.sv */
`timescale 1ns/10ps
`default_nettype none

module blend_core #(
	parameter int MAX_W_LOG = 12
) (
	input  wire                            clk,
	input  wire                            resetn,
	input  wire blend_cfg_pkg::blend_cfg_t cfg,
	vid_stream_if.sink                     bg,
	input  wire                            covers1,
	input  wire                            covers2,
	input  wire                            ready1,
	input  wire                            ready2,
	input  wire video_pkg::ovl_pixel_t     pix1,
	input  wire video_pkg::ovl_pixel_t     pix2,
	output video_pkg::coord_t              cur_x,
	output video_pkg::coord_t              cur_y,
	output logic                           take,
	output logic                           frame_idle,
	vid_stream_if.source                   out,
	output logic                           bg_sync_error
);
	import video_pkg::*;

	// Widest legal line. Larger written widths are clamped to it.
	localparam coord_t MAX_W = coord_t'((1 << MAX_W_LOG) - 1);

	coord_t     out_w;
	coord_t     out_h;
	logic       size_ok;
	logic       out_free;
	logic       first_pix;
	logic       last_col;
	logic       last_row;
	logic       use1;
	logic       use2;
	rgb_pixel_t mix;

	assign out_w = (cfg.out_width > MAX_W) ? MAX_W : cfg.out_width;
	assign out_h = cfg.out_height;
	assign size_ok = (out_w != '0) && (out_h != '0);	// Stall until a real frame size is active.

	assign first_pix = (cur_x == '0) && (cur_y == '0);
	assign last_col  = (cur_x == out_w - coord_t'(1));
	assign last_row  = (cur_y == out_h - coord_t'(1));

	// The output register can take a pixel when it is empty or drains this cycle.
	assign out_free = !out.tvalid || out.tready;
	assign take = size_ok && out_free && bg.tvalid && ready1 && ready2;
	assign bg.tready = take;

	// A take at the origin starts the frame, so the active set must not change under it.
	assign frame_idle = first_pix && !take;

	// Raster position of the next output pixel.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cur_x <= '0;
			cur_y <= '0;
		end else if (take) begin
			if (last_col) begin
				cur_x <= '0;
				cur_y <= last_row ? '0 : cur_y + coord_t'(1);
			end else begin
				cur_x <= cur_x + coord_t'(1);
			end
		end
	end

	// A zero overlay pixel is transparent.
	assign use1 = covers1 && (pix1 != '0);
	assign use2 = covers2 && (pix2 != '0);

	always_comb begin
		if (use1 && (!use2 || cfg.order_1over2)) begin
			mix = {pix1, pix1, pix1};
		end else if (use2) begin
			mix = {pix2, pix2, pix2};
		end else begin
			mix = bg.tdata[23:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			out.tvalid <= 1'b0;
		end else if (take) begin
			out.tvalid <= 1'b1;
		end else if (out.tready) begin
			out.tvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out.tdata <= mix;
			out.tuser <= first_pix;
			out.tlast <= last_col;
		end
	end

	// The background framing has to follow the output raster exactly.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			bg_sync_error <= 1'b0;
		end else if (take && ((bg.tuser != first_pix) || (bg.tlast != last_col))) begin
			bg_sync_error <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* blender/blend_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module blend_regs (
	input  wire                                    clk,
	input  wire                                    resetn,
	input  wire                                    cfg_we,
	input  wire [blend_cfg_pkg::CFG_ADDR_W-1:0]    cfg_addr,
	input  wire [blend_cfg_pkg::CFG_DATA_W-1:0]    cfg_wdata,
	input  wire                                    frame_idle,
	output blend_cfg_pkg::blend_cfg_t              cfg
);
	import video_pkg::*;
	import blend_cfg_pkg::*;

	blend_cfg_t shadow;
	coord_t     wdata_c;

	assign wdata_c = cfg_wdata[COORD_W-1:0];	// Sizes and positions use the low bits.

	// Software writes land in the shadow set.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			shadow <= '0;
		end else if (cfg_we) begin
			case (cfg_addr)
				REG_OUT_W:     shadow.out_width    <= wdata_c;
				REG_OUT_H:     shadow.out_height   <= wdata_c;
				REG_W1_LEFT:   shadow.win1.left    <= wdata_c;
				REG_W1_TOP:    shadow.win1.top     <= wdata_c;
				REG_W1_WIDTH:  shadow.win1.width   <= wdata_c;
				REG_W1_HEIGHT: shadow.win1.height  <= wdata_c;
				REG_W2_LEFT:   shadow.win2.left    <= wdata_c;
				REG_W2_TOP:    shadow.win2.top     <= wdata_c;
				REG_W2_WIDTH:  shadow.win2.width   <= wdata_c;
				REG_W2_HEIGHT: shadow.win2.height  <= wdata_c;
				REG_ORDER:     shadow.order_1over2 <= cfg_wdata[0];
				default: begin
				end
			endcase
		end
	end

	// The active set only follows the shadow between frames, so a frame never mixes
	// two configurations.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cfg <= '0;
		end else if (frame_idle) begin
			cfg <= shadow;
		end
	end

endmodule

`default_nettype wire

/* blender/layer_window.sv */
`timescale 1ns/10ps
`default_nettype none

module layer_window (
	input  wire                      clk,
	input  wire                      resetn,
	input  wire blend_cfg_pkg::win_t win,
	input  wire video_pkg::coord_t   cur_x,
	input  wire video_pkg::coord_t   cur_y,
	input  wire                      take,
	vid_stream_if.sink               ovl,
	output logic                     covers,
	output logic                     ready_pix,
	output video_pkg::ovl_pixel_t    pix,
	output logic                     sync_error
);
	import video_pkg::*;

	coord_t col;
	coord_t row;
	logic   in_x;
	logic   in_y;
	logic   exp_first;
	logic   exp_last;
	logic   xfer;

	// The subtraction is only looked at once the coordinate is past the window origin.
	assign in_x = (cur_x >= win.left) && ((cur_x - win.left) < win.width);
	assign in_y = (cur_y >= win.top) && ((cur_y - win.top) < win.height);
	assign covers = in_x && in_y;

	assign ready_pix = !covers || ovl.tvalid;
	assign ovl.tready = take && covers;
	assign pix = ovl.tdata;
	assign xfer = ovl.tvalid && ovl.tready;

	assign exp_first = (col == '0) && (row == '0);
	assign exp_last  = (col == win.width - coord_t'(1));

	// The position inside the window advances with each overlay transfer.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			col <= '0;
			row <= '0;
		end else if (xfer) begin
			if (exp_last) begin
				col <= '0;
				row <= (row == win.height - coord_t'(1)) ? '0 : row + coord_t'(1);
			end else begin
				col <= col + coord_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			sync_error <= 1'b0;
		end else if (xfer && ((ovl.tuser != exp_first) || (ovl.tlast != exp_last))) begin
			sync_error <= 1'b1;	// Sticky until the next reset.
		end
	end

endmodule

`default_nettype wire

/* common/blend_cfg_pkg.sv */
`default_nettype none

// Register map and configuration structs of the blender.
package blend_cfg_pkg;
	import video_pkg::*;

	localparam int CFG_ADDR_W = 4;
	localparam int CFG_DATA_W = 16;

	localparam logic [CFG_ADDR_W-1:0] REG_OUT_W     = 'd0;
	localparam logic [CFG_ADDR_W-1:0] REG_OUT_H     = 'd1;
	localparam logic [CFG_ADDR_W-1:0] REG_W1_LEFT   = 'd2;
	localparam logic [CFG_ADDR_W-1:0] REG_W1_TOP    = 'd3;
	localparam logic [CFG_ADDR_W-1:0] REG_W1_WIDTH  = 'd4;
	localparam logic [CFG_ADDR_W-1:0] REG_W1_HEIGHT = 'd5;
	localparam logic [CFG_ADDR_W-1:0] REG_W2_LEFT   = 'd6;
	localparam logic [CFG_ADDR_W-1:0] REG_W2_TOP    = 'd7;
	localparam logic [CFG_ADDR_W-1:0] REG_W2_WIDTH  = 'd8;
	localparam logic [CFG_ADDR_W-1:0] REG_W2_HEIGHT = 'd9;
	localparam logic [CFG_ADDR_W-1:0] REG_ORDER     = 'd10;	// Bit 0 is order_1over2.

	// Overlay window placement in output coordinates.
	typedef struct packed {
		coord_t left;
		coord_t top;
		coord_t width;
		coord_t height;
	} win_t;

	typedef struct packed {
		coord_t out_width;
		coord_t out_height;
		win_t   win1;
		win_t   win2;
		logic   order_1over2;	// One lets s1 win where both windows are opaque.
	} blend_cfg_t;

endpackage

`default_nettype wire

/* common/vid_stream_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Valid/ready pixel stream. A pixel moves on a rising edge with tvalid and tready high.
interface vid_stream_if #(
	parameter type pixel_t = logic [7:0]
) ();

	logic   tvalid;
	pixel_t tdata;
	logic   tuser;	// First pixel of a frame.
	logic   tlast;	// Last pixel of a line.
	logic   tready;

	modport source (
		output tvalid, tdata, tuser, tlast,
		input  tready
	);

	modport sink (
		input  tvalid, tdata, tuser, tlast,
		output tready
	);

endinterface

`default_nettype wire

/* common/video_pkg.sv */
`default_nettype none

// Pixel and coordinate types shared by the stream and blend logic.
package video_pkg;

	// Width of every frame coordinate and every size.
	localparam int COORD_W = 12;

	typedef logic [COORD_W-1:0] coord_t;

	// Background pixel. Bits 23 to 0 are RGB and the top byte is ignored.
	typedef logic [31:0] bg_pixel_t;

	typedef logic [7:0] ovl_pixel_t;	// Overlay grey value.

	typedef logic [23:0] rgb_pixel_t;	// Output pixel with R in the top byte.

endpackage

`default_nettype wire

/* hw/video_blender.sv */
`timescale 1ns/10ps
`default_nettype none

module video_blender #(
	parameter int MAX_W_LOG = 12
) (
	input  wire                                 clk,
	input  wire                                 resetn,
	input  wire                                 cfg_we,
	input  wire [blend_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input  wire [blend_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
	input  wire                                 s0_tvalid,
	input  wire video_pkg::bg_pixel_t           s0_tdata,
	input  wire                                 s0_tuser,
	input  wire                                 s0_tlast,
	output logic                                s0_tready,
	input  wire                                 s1_tvalid,
	input  wire video_pkg::ovl_pixel_t          s1_tdata,
	input  wire                                 s1_tuser,
	input  wire                                 s1_tlast,
	output logic                                s1_tready,
	input  wire                                 s2_tvalid,
	input  wire video_pkg::ovl_pixel_t          s2_tdata,
	input  wire                                 s2_tuser,
	input  wire                                 s2_tlast,
	output logic                                s2_tready,
	output logic                                m_tvalid,
	output video_pkg::rgb_pixel_t               m_tdata,
	output logic                                m_tuser,
	output logic                                m_tlast,
	input  wire                                 m_tready,
	output logic [2:0]                          sync_error
);
	import video_pkg::*;
	import blend_cfg_pkg::*;

	blend_cfg_t cfg;
	coord_t     cur_x;
	coord_t     cur_y;
	logic       take;
	logic       frame_idle;
	logic       covers1;
	logic       covers2;
	logic       ready1;
	logic       ready2;
	ovl_pixel_t pix1;
	ovl_pixel_t pix2;
	logic       bg_err;
	logic       s1_err;
	logic       s2_err;

	vid_stream_if #(.pixel_t(bg_pixel_t))  bg_if ();
	vid_stream_if #(.pixel_t(ovl_pixel_t)) ovl1_if ();
	vid_stream_if #(.pixel_t(ovl_pixel_t)) ovl2_if ();
	vid_stream_if #(.pixel_t(rgb_pixel_t)) out_if ();

	assign bg_if.tvalid = s0_tvalid;
	assign bg_if.tdata  = s0_tdata;
	assign bg_if.tuser  = s0_tuser;
	assign bg_if.tlast  = s0_tlast;
	assign s0_tready    = bg_if.tready;

	assign ovl1_if.tvalid = s1_tvalid;
	assign ovl1_if.tdata  = s1_tdata;
	assign ovl1_if.tuser  = s1_tuser;
	assign ovl1_if.tlast  = s1_tlast;
	assign s1_tready      = ovl1_if.tready;

	assign ovl2_if.tvalid = s2_tvalid;
	assign ovl2_if.tdata  = s2_tdata;
	assign ovl2_if.tuser  = s2_tuser;
	assign ovl2_if.tlast  = s2_tlast;
	assign s2_tready      = ovl2_if.tready;

	assign m_tvalid      = out_if.tvalid;
	assign m_tdata       = out_if.tdata;
	assign m_tuser       = out_if.tuser;
	assign m_tlast       = out_if.tlast;
	assign out_if.tready = m_tready;

	assign sync_error = {s2_err, s1_err, bg_err};	// Bit 0 is s0.

	blend_regs u_regs (
		.clk        (clk),
		.resetn     (resetn),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.frame_idle (frame_idle),
		.cfg        (cfg)
	);

	layer_window u_win1 (
		.clk        (clk),
		.resetn     (resetn),
		.win        (cfg.win1),
		.cur_x      (cur_x),
		.cur_y      (cur_y),
		.take       (take),
		.ovl        (ovl1_if.sink),
		.covers     (covers1),
		.ready_pix  (ready1),
		.pix        (pix1),
		.sync_error (s1_err)
	);

	layer_window u_win2 (
		.clk        (clk),
		.resetn     (resetn),
		.win        (cfg.win2),
		.cur_x      (cur_x),
		.cur_y      (cur_y),
		.take       (take),
		.ovl        (ovl2_if.sink),
		.covers     (covers2),
		.ready_pix  (ready2),
		.pix        (pix2),
		.sync_error (s2_err)
	);

	blend_core #(
		.MAX_W_LOG (MAX_W_LOG)
	) u_core (
		.clk           (clk),
		.resetn        (resetn),
		.cfg           (cfg),
		.bg            (bg_if.sink),
		.covers1       (covers1),
		.covers2       (covers2),
		.ready1        (ready1),
		.ready2        (ready2),
		.pix1          (pix1),
		.pix2          (pix2),
		.cur_x         (cur_x),
		.cur_y         (cur_y),
		.take          (take),
		.frame_idle    (frame_idle),
		.out           (out_if.source),
		.bg_sync_error (bg_err)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compiles and runs the video blender testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

{ verilator --binary --timing --assert -Wno-fatal --top-module tb_video_blender \
	-f video_blender.f && ./obj_dir/Vtb_video_blender; } > sim.log 2>&1 \
	|| echo "Simulation failed" >> sim.log

grep -q "Simulation completed successfully" sim.log || echo "Simulation failed" >> sim.log
cat sim.log

grep -q "Simulation failed" sim.log && exit 1
exit 0

/* testbench/tb_video_blender.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_video_blender;
	import blend_cfg_pkg::*;

	logic        clk;
	logic        resetn;
	logic        cfg_we;
	logic [3:0]  cfg_addr;
	logic [15:0] cfg_wdata;
	logic        s0_tvalid;
	logic [31:0] s0_tdata;
	logic        s0_tuser;
	logic        s0_tlast;
	logic        s0_tready;
	logic        s1_tvalid;
	logic [7:0]  s1_tdata;
	logic        s1_tuser;
	logic        s1_tlast;
	logic        s1_tready;
	logic        s2_tvalid;
	logic [7:0]  s2_tdata;
	logic        s2_tuser;
	logic        s2_tlast;
	logic        s2_tready;
	logic        m_tvalid;
	logic [23:0] m_tdata;
	logic        m_tuser;
	logic        m_tlast;
	logic        m_tready;
	logic [2:0]  sync_error;

	int seed = 90;
	int errors = 0;
	int test_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int rx_count = 0;
	int rx_start;
	bit bp_on = 1'b0;	// Random gaps on m_tready.
	string cur_test = "reset";

	// Beats waiting to be sent, {tuser, tlast, data}, and the predicted output pixels.
	logic [33:0] q0[$];
	logic [33:0] q1[$];
	logic [33:0] q2[$];
	logic [25:0] exp_q[$];

	// Configuration of the frame that is built next.
	int frm_w;
	int frm_h;
	int order_1over2;
	int win_left[2];
	int win_top[2];
	int win_wid[2];
	int win_hgt[2];

	video_blender #(
		.MAX_W_LOG (12)
	) UUT (
		.clk        (clk),
		.resetn     (resetn),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.s0_tvalid  (s0_tvalid),
		.s0_tdata   (s0_tdata),
		.s0_tuser   (s0_tuser),
		.s0_tlast   (s0_tlast),
		.s0_tready  (s0_tready),
		.s1_tvalid  (s1_tvalid),
		.s1_tdata   (s1_tdata),
		.s1_tuser   (s1_tuser),
		.s1_tlast   (s1_tlast),
		.s1_tready  (s1_tready),
		.s2_tvalid  (s2_tvalid),
		.s2_tdata   (s2_tdata),
		.s2_tuser   (s2_tuser),
		.s2_tlast   (s2_tlast),
		.s2_tready  (s2_tready),
		.m_tvalid   (m_tvalid),
		.m_tdata    (m_tdata),
		.m_tuser    (m_tuser),
		.m_tlast    (m_tlast),
		.m_tready   (m_tready),
		.sync_error (sync_error)
	);

	always #2 clk = ~clk;

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// Stream drivers with random valid gaps, and the output monitor.
	always @(posedge clk) begin
		logic [31:0] r;
		if (!resetn) begin
			s0_tvalid <= 1'b0;
			s1_tvalid <= 1'b0;
			s2_tvalid <= 1'b0;
			m_tready <= 1'b0;
		end else begin
			if (m_tvalid && m_tready) begin
				if (exp_q.size() == 0) begin
					$display("Test %s: an output pixel arrived that was not expected", cur_test);
					errors++;
				end else begin
					check(cur_test, {6'd0, exp_q[0]}, {6'd0, m_tuser, m_tlast, m_tdata});
					void'(exp_q.pop_front());
				end
				rx_count++;
			end
			if (s0_tvalid && s0_tready)
				void'(q0.pop_front());
			if (s1_tvalid && s1_tready)
				void'(q1.pop_front());
			if (s2_tvalid && s2_tready)
				void'(q2.pop_front());
			r = $random(seed);
			if (!(s0_tvalid && !s0_tready)) begin	// A stalled beat is held.
				s0_tvalid <= (q0.size() > 0) && (r[1:0] != 2'd0);
				if (q0.size() > 0)
					{s0_tuser, s0_tlast, s0_tdata} <= q0[0];
			end
			if (!(s1_tvalid && !s1_tready)) begin
				s1_tvalid <= (q1.size() > 0) && (r[3:2] != 2'd0);
				if (q1.size() > 0)
					{s1_tuser, s1_tlast, s1_tdata} <= {q1[0][33:32], q1[0][7:0]};
			end
			if (!(s2_tvalid && !s2_tready)) begin
				s2_tvalid <= (q2.size() > 0) && (r[5:4] != 2'd0);
				if (q2.size() > 0)
					{s2_tuser, s2_tlast, s2_tdata} <= {q2[0][33:32], q2[0][7:0]};
			end
			m_tready <= bp_on ? r[6] : 1'b1;
		end
	end

	task automatic write_reg(input int addr, input int value);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_addr <= addr[3:0];
		cfg_wdata <= value[15:0];
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	task automatic program_cfg();
		write_reg(REG_OUT_W, frm_w);
		write_reg(REG_OUT_H, frm_h);
		write_reg(REG_W1_LEFT, win_left[0]);
		write_reg(REG_W1_TOP, win_top[0]);
		write_reg(REG_W1_WIDTH, win_wid[0]);
		write_reg(REG_W1_HEIGHT, win_hgt[0]);
		write_reg(REG_W2_LEFT, win_left[1]);
		write_reg(REG_W2_TOP, win_top[1]);
		write_reg(REG_W2_WIDTH, win_wid[1]);
		write_reg(REG_W2_HEIGHT, win_hgt[1]);
		write_reg(REG_ORDER, order_1over2);
	endtask

	task automatic set_win(input int k, input int left, input int top, input int wid,
			input int hgt);
		win_left[k] = left;
		win_top[k] = top;
		win_wid[k] = wid;
		win_hgt[k] = hgt;
	endtask

	// Queues one frame on all three inputs and predicts every output pixel.
	task automatic start_frame(input bit bad_tlast);
		int x;
		int y;
		int k;
		logic [31:0] r;
		logic [31:0] bg;
		logic [7:0] p[2];
		logic in_w[2];
		logic use_w[2];
		logic first;
		logic last;
		logic wlast;
		logic [23:0] rgb;
		for (y = 0; y < frm_h; y++) begin
			for (x = 0; x < frm_w; x++) begin
				first = (x == 0) && (y == 0);
				last = (x == frm_w - 1);
				bg = $random(seed);
				q0.push_back({first, last, bg});
				for (k = 0; k < 2; k++) begin
					r = $random(seed);
					p[k] = (r[9:8] == 2'd0) ? 8'd0 : r[7:0];	// Some pixels are transparent.
					in_w[k] = (x >= win_left[k]) && (x < win_left[k] + win_wid[k]) &&
						(y >= win_top[k]) && (y < win_top[k] + win_hgt[k]);
					use_w[k] = in_w[k] && (p[k] != 8'd0);
					wlast = (x == win_left[k] + win_wid[k] - 1);
					if (bad_tlast && (k == 0) && (x == win_left[k]) && (y == win_top[k]))
						wlast = !wlast;
					if (in_w[k] && (k == 0))
						q1.push_back({(x == win_left[k]) && (y == win_top[k]), wlast, 24'd0, p[k]});
					if (in_w[k] && (k == 1))
						q2.push_back({(x == win_left[k]) && (y == win_top[k]), wlast, 24'd0, p[k]});
				end
				if (use_w[0] && (!use_w[1] || (order_1over2 != 0)))
					rgb = {3{p[0]}};
				else if (use_w[1])
					rgb = {3{p[1]}};
				else
					rgb = bg[23:0];
				exp_q.push_back({first, last, rgb});
			end
		end
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while ((exp_q.size() != 0 || q0.size() != 0 || q1.size() != 0 || q2.size() != 0)
				&& n < limit) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0 || q0.size() != 0 || q1.size() != 0 || q2.size() != 0) begin
			$display("Test %s: timed out waiting for the frame to finish", cur_test);
			errors++;
			exp_q.delete();
			q0.delete();
			q1.delete();
			q2.delete();
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic wait_outputs(input int target, input int limit);
		int n;
		n = 0;
		while (rx_count < target && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (rx_count < target) begin
			$display("Test %s: timed out waiting for output pixels", cur_test);
			errors++;
		end
	endtask

	task automatic run_frame(input bit bad_tlast, input logic [2:0] exp_sync);
		program_cfg();
		repeat (3) @(posedge clk);
		rx_start = rx_count;
		start_frame(bad_tlast);
		wait_idle(5000);
		check("output count", frm_w * frm_h, rx_count - rx_start);
		check("sync_error", {29'd0, exp_sync}, {29'd0, sync_error});
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		if (errors == test_errors) begin
			$display("PASS %s", cur_test);
			tests_passed++;
		end else begin
			$display("FAIL %s", cur_test);
			tests_failed++;
		end
	endtask

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = 4'd0;
		cfg_wdata = 16'd0;
		s0_tvalid = 1'b0;
		s0_tdata = 32'd0;
		s0_tuser = 1'b0;
		s0_tlast = 1'b0;
		s1_tvalid = 1'b0;
		s1_tdata = 8'd0;
		s1_tuser = 1'b0;
		s1_tlast = 1'b0;
		s2_tvalid = 1'b0;
		s2_tdata = 8'd0;
		s2_tuser = 1'b0;
		s2_tlast = 1'b0;
		m_tready = 1'b0;
		repeat (16) @(posedge clk);
		resetn <= 1'b1;
		repeat (4) @(posedge clk);

		begin_test("background only");
		frm_w = 10;
		frm_h = 10;
		order_1over2 = 0;
		set_win(0, 0, 0, 0, 0);
		set_win(1, 0, 0, 0, 0);
		run_frame(1'b0, 3'b000);
		end_test();

		begin_test("overlay placement");
		set_win(0, 0, 0, 4, 7);
		set_win(1, 5, 4, 5, 4);
		run_frame(1'b0, 3'b000);
		end_test();

		begin_test("priority");
		set_win(0, 1, 1, 6, 6);
		set_win(1, 4, 3, 5, 5);
		order_1over2 = 1;
		run_frame(1'b0, 3'b000);
		order_1over2 = 0;
		run_frame(1'b0, 3'b000);
		end_test();

		begin_test("back-pressure");
		bp_on = 1'b1;
		frm_w = 16;
		frm_h = 12;
		order_1over2 = 1;
		run_frame(1'b0, 3'b000);
		bp_on = 1'b0;
		end_test();

		// The second write lands mid-frame and must only show in the next frame.
		begin_test("frame boundary configuration");
		frm_w = 10;
		frm_h = 10;
		set_win(0, 0, 0, 4, 7);
		set_win(1, 5, 4, 5, 4);
		program_cfg();
		repeat (3) @(posedge clk);
		rx_start = rx_count;
		start_frame(1'b0);
		wait_outputs(rx_start + 5, 2000);
		set_win(0, 2, 5, 7, 3);
		program_cfg();
		check("frame running during write", 32'd1, {31'd0, exp_q.size() != 0});
		wait_idle(5000);
		rx_start = rx_count;
		start_frame(1'b0);
		wait_idle(5000);
		check("output count", frm_w * frm_h, rx_count - rx_start);
		end_test();

		begin_test("framing error");
		set_win(0, 0, 0, 4, 7);
		run_frame(1'b1, 3'b010);
		end_test();

		$display("Tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/video_blender_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module video_blender_checker (
	input wire        clk,
	input wire        resetn,
	input wire        take,
	input wire [11:0] cur_x,
	input wire [11:0] cur_y,
	input wire        m_tvalid,
	input wire        m_tready,
	input wire [23:0] m_tdata,
	input wire        m_tuser,
	input wire        m_tlast,
	input wire        bg_sync_error
);

	// A stalled output pixel stays put until the sink accepts it.
	stable_when_stalled: assert property (@(posedge clk) disable iff (!resetn)
		(m_tvalid && !m_tready) |=> (m_tvalid && $stable({m_tdata, m_tuser, m_tlast})))
		else $error("output pixel changed while the sink was stalling");

	// A stall holds the raster position because no input may be taken.
	no_take_when_stalled: assert property (@(posedge clk) disable iff (!resetn)
		(m_tvalid && !m_tready) |=> $stable({cur_x, cur_y}))
		else $error("inputs were consumed while the output register was full");

	// Registers come out of reset empty and error free.
	quiet_in_reset: assert property (@(posedge clk)
		!resetn |=> (!m_tvalid && !take && !bg_sync_error))
		else $error("core was active during reset");

endmodule

bind blend_core video_blender_checker u_checker (
	.clk           (clk),
	.resetn        (resetn),
	.take          (take),
	.cur_x         (cur_x),
	.cur_y         (cur_y),
	.m_tvalid      (out.tvalid),
	.m_tready      (out.tready),
	.m_tdata       (out.tdata),
	.m_tuser       (out.tuser),
	.m_tlast       (out.tlast),
	.bg_sync_error (bg_sync_error)
);

`default_nettype wire

/* video_blender.f */
common/video_pkg.sv
common/blend_cfg_pkg.sv
common/vid_stream_if.sv
blender/blend_regs.sv
blender/layer_window.sv
blender/blend_core.sv
hw/video_blender.sv
testbench/video_blender_checker.sv
testbench/tb_video_blender.sv
